//--- verilog.f
+incdir+.
ex_pkg.sv
insn_decoder.sv
id_ex_regs.sv
alu_unit.sv
branch_resolver.sv
ex_merge.sv
ex_top.sv
tb_ex_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ex_top -f verilog.f -o tb_ex_top

# The simulator exit code is not trusted alone, the log decides
./obj_dir/tb_ex_top | tee sim.log

if grep -q -F "*** PASSED ***" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

//--- tb_ex_top.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module tb_ex_top
	import ex_pkg::*;
;

	localparam int NUM_RESULTS = 2000;
	localparam int TIMEOUT_NS = 20 * NUM_RESULTS * 10;

	// One expected result per accepted instruction
	typedef struct packed {
		logic we;
		logic [`EX_REGW-1:0] rd;
		logic [`EX_XLEN-1:0] data;
		logic [`EX_XLEN-1:0] npc;
		logic redir;
		logic ill;
	} exp_t;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic in_ready_o;
	insn_u insn_i;
	logic [`EX_XLEN-1:0] pc_i, rs1_data_i, rs2_data_i, pred_pc_i;
	logic out_valid_o;
	logic out_ready_i;
	logic rd_we_o;
	logic [`EX_REGW-1:0] rd_addr_o;
	logic [`EX_XLEN-1:0] rd_data_o, next_pc_o;
	logic redirect_o;
	logic illegal_o;

	integer seed = 32'h6201;
	int n_results;
	logic issue_done; // Offer was taken at the last edge
	logic drop;
	exp_t pend; // Expected result of the current offer
	exp_t head;
	exp_t exp_q[$];

	ex_top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_word(input string name, input logic [`EX_XLEN-1:0] got,
		input logic [`EX_XLEN-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_reg(input string name, input logic [`EX_REGW-1:0] got,
		input logic [`EX_REGW-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// Reference behavior straight from the RV32I encodings
	function automatic exp_t model_insn(input logic [31:0] insn, input logic [31:0] pc,
		input logic [31:0] a, input logic [31:0] b);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [31:0] imm_i, imm_b, imm_u, imm_j, op2;
		logic taken;
		exp_t e;
		opc = insn[6:0];
		f3 = insn[14:12];
		imm_i = {{20{insn[31]}}, insn[31:20]};
		imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
		imm_u = {insn[31:12], 12'd0};
		imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
		op2 = (opc == OPC_OP) ? b : imm_i;
		taken = 1'b0;
		e.we = (insn[11:7] != 5'd0);
		e.rd = insn[11:7];
		e.data = 32'd0;
		e.npc = pc + 32'd4;
		e.redir = 1'b0;
		e.ill = 1'b0;
		case (opc)
			OPC_OP, OPC_OP_IMM:
			begin
				case (f3)
					3'd0: e.data = (opc == OPC_OP && insn[30]) ? a - op2 : a + op2;
					3'd1: e.data = a << op2[4:0];
					3'd2: e.data = {31'd0, $signed(a) < $signed(op2)};
					3'd3: e.data = {31'd0, a < op2};
					3'd4: e.data = a ^ op2;
					3'd5:
						if (insn[30])
							e.data = $signed(a) >>> op2[4:0];
						else
							e.data = a >> op2[4:0];
					3'd6: e.data = a | op2;
					default: e.data = a & op2;
				endcase
			end
			OPC_LUI: e.data = imm_u;
			OPC_AUIPC: e.data = pc + imm_u;
			OPC_JAL:
			begin
				e.data = pc + 32'd4;
				e.npc = pc + imm_j;
			end
			OPC_JALR:
			begin
				e.data = pc + 32'd4;
				e.npc = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH:
			begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					default: taken = a >= b;
				endcase
				e.we = 1'b0;
				if (taken)
					e.npc = pc + imm_b;
			end
			default:
			begin
				e.we = 1'b0;
				e.ill = 1'b1;
			end
		endcase
		return e;
	endfunction

	task automatic new_offer();
		logic [31:0] r, insn, pc, a, b, pred;
		exp_t e;
		r = $random(seed);
		insn = $random(seed);
		case (r[2:0])
			3'd0:
			begin
				insn[31:25] = {1'b0, insn[30] && (insn[14:12] == 3'd0 || insn[14:12] == 3'd5),
					5'd0};
				insn[6:0] = OPC_OP;
			end
			3'd1:
			begin
				if (insn[14:12] == 3'd1)
					insn[31:25] = 7'd0;
				else if (insn[14:12] == 3'd5)
					insn[31:25] = {1'b0, insn[30], 5'd0}; // SRLI or SRAI
				insn[6:0] = OPC_OP_IMM;
			end
			3'd2: insn[6:0] = OPC_LUI;
			3'd3: insn[6:0] = OPC_AUIPC;
			3'd4: insn[6:0] = OPC_JAL;
			3'd5:
			begin
				insn[14:12] = 3'd0;
				insn[6:0] = OPC_JALR;
			end
			3'd6:
			begin
				if (insn[14:13] == 2'b01)
					insn[14] = 1'b1; // Skip the reserved branch codes
				insn[6:0] = OPC_BRANCH;
			end
			default:
				case (r[4:3])
					2'd0: insn[6:0] = 7'b0000011;
					2'd1: insn[6:0] = 7'b0100011;
					2'd2: insn[6:0] = 7'b0001111;
					default: insn[6:0] = 7'b1110011;
				endcase
		endcase
		if (r[7:5] == 3'd0)
			insn[11:7] = 5'd0;
		pc = $random(seed);
		pc[1:0] = 2'b00;
		a = $random(seed);
		b = (r[9:8] == 2'd0) ? a : $random(seed);
		// Register file reads x0 as zero
		if (insn[19:15] == 5'd0)
			a = 32'd0;
		if (insn[24:20] == 5'd0)
			b = 32'd0;
		e = model_insn(insn, pc, a, b);
		pred = $random(seed);
		if (r[10])
			pred = e.npc;
		else if (pred == e.npc)
			pred = pred ^ 32'd4;
		e.redir = (pred != e.npc);
		in_valid_i = (r[12:11] != 2'b00);
		insn_i = insn;
		pc_i = pc;
		rs1_data_i = a;
		rs2_data_i = b;
		pred_pc_i = pred;
		pend = e;
	endtask

	task automatic drive_inputs();
		if (!in_valid_i || issue_done)
			new_offer();
		out_ready_i = (($random(seed) & 7) > 1);
	endtask

	always @(posedge clk)
	begin
		if (!rst_i)
		begin
			check_bit("out_valid_o", out_valid_o, exp_q.size() != 0);
			check_bit("in_ready_o", in_ready_o, !(exp_q.size() != 0 && !out_ready_i));
			issue_done = in_valid_i && in_ready_o;
			drop = 1'b0;
			if (out_valid_o)
			begin
				head = exp_q[0]; // Checked every cycle it is held
				check_bit("rd_we_o", rd_we_o, head.we);
				check_bit("redirect_o", redirect_o, head.redir);
				check_bit("illegal_o", illegal_o, head.ill);
				check_word("next_pc_o", next_pc_o, head.npc);
				if (head.we)
				begin
					check_reg("rd_addr_o", rd_addr_o, head.rd);
					check_word("rd_data_o", rd_data_o, head.data);
				end
				if (out_ready_i)
				begin
					void'(exp_q.pop_front());
					n_results++;
					drop = head.redir; // Same-cycle issue is on the wrong path
				end
			end
			if (issue_done && !drop)
				exp_q.push_back(pend);
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		abort_run($sformatf("Timeout after %0d ns with only %0d results seen",
			TIMEOUT_NS, n_results));
	end

	initial
	begin
		n_results = 0;
		issue_done = 1'b0;
		drop = 1'b0;
		pend = '0;
		head = '0;
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		insn_i = 32'd0;
		pc_i = 32'd0;
		rs1_data_i = 32'd0;
		rs2_data_i = 32'd0;
		pred_pc_i = 32'd0;
		out_ready_i = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		check_bit("out_valid_o", out_valid_o, 1'b0);
		check_bit("in_ready_o", in_ready_o, 1'b1);
		while (n_results < NUM_RESULTS)
		begin
			drive_inputs();
			@(negedge clk);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- ex_top.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_top
	import ex_pkg::*;
(
	input logic clk,
	input logic rst_i,
	input logic in_valid_i,
	output logic in_ready_o,
	input insn_u insn_i,
	input logic [`EX_XLEN-1:0] pc_i,
	input logic [`EX_XLEN-1:0] rs1_data_i,
	input logic [`EX_XLEN-1:0] rs2_data_i,
	input logic [`EX_XLEN-1:0] pred_pc_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic rd_we_o,
	output logic [`EX_REGW-1:0] rd_addr_o,
	output logic [`EX_XLEN-1:0] rd_data_o,
	output logic [`EX_XLEN-1:0] next_pc_o,
	output logic redirect_o,
	output logic illegal_o
);

	// Decode stage outputs
	logic [`EX_XLEN-1:0] dec_imm;
	alu_op_e dec_alu_op;
	br_cond_e dec_br_cond;
	logic dec_src_a_pc, dec_src_b_imm, dec_jal, dec_jalr, dec_rd_we, dec_illegal;
	logic [`EX_REGW-1:0] dec_rd_addr, dec_rs1_addr, dec_rs2_addr;

	// Execute stage fields
	logic ex_valid;
	logic [`EX_XLEN-1:0] ex_imm, ex_pc, ex_pred_pc, ex_rs1_data, ex_rs2_data;
	alu_op_e ex_alu_op;
	br_cond_e ex_br_cond;
	logic ex_src_a_pc, ex_src_b_imm, ex_jal, ex_jalr, ex_rd_we, ex_illegal;
	logic [`EX_REGW-1:0] ex_rd_addr;

	logic [`EX_XLEN-1:0] alu_result, br_next_pc, br_link;
	logic br_mispredict;
	logic stall, flush;

	assign stall = ex_valid && !out_ready_i;
	assign in_ready_o = !stall;

	insn_decoder u_decoder (
		.insn_i(insn_i),
		.imm_o(dec_imm),
		.alu_op_o(dec_alu_op),
		.src_a_pc_o(dec_src_a_pc),
		.src_b_imm_o(dec_src_b_imm),
		.br_cond_o(dec_br_cond),
		.jal_o(dec_jal),
		.jalr_o(dec_jalr),
		.rd_we_o(dec_rd_we),
		.rd_addr_o(dec_rd_addr),
		.rs1_addr_o(dec_rs1_addr),
		.rs2_addr_o(dec_rs2_addr),
		.illegal_o(dec_illegal)
	);

	id_ex_regs u_id_ex (
		.clk(clk),
		.rst_i(rst_i),
		.flush_i(flush),
		.stall_i(stall),
		.valid_i(in_valid_i),
		.imm_i(dec_imm),
		.alu_op_i(dec_alu_op),
		.src_a_pc_i(dec_src_a_pc),
		.src_b_imm_i(dec_src_b_imm),
		.br_cond_i(dec_br_cond),
		.jal_i(dec_jal),
		.jalr_i(dec_jalr),
		.rd_we_i(dec_rd_we),
		.rd_addr_i(dec_rd_addr),
		.rs1_addr_i(dec_rs1_addr),
		.rs2_addr_i(dec_rs2_addr),
		.illegal_i(dec_illegal),
		.pc_i(pc_i),
		.pred_pc_i(pred_pc_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.valid_o(ex_valid),
		.imm_o(ex_imm),
		.alu_op_o(ex_alu_op),
		.src_a_pc_o(ex_src_a_pc),
		.src_b_imm_o(ex_src_b_imm),
		.br_cond_o(ex_br_cond),
		.jal_o(ex_jal),
		.jalr_o(ex_jalr),
		.rd_we_o(ex_rd_we),
		.rd_addr_o(ex_rd_addr),
		.illegal_o(ex_illegal),
		.pc_o(ex_pc),
		.pred_pc_o(ex_pred_pc),
		.rs1_data_o(ex_rs1_data),
		.rs2_data_o(ex_rs2_data)
	);

	alu_unit u_alu (
		.alu_op_i(ex_alu_op),
		.src_a_pc_i(ex_src_a_pc),
		.src_b_imm_i(ex_src_b_imm),
		.rs1_data_i(ex_rs1_data),
		.rs2_data_i(ex_rs2_data),
		.pc_i(ex_pc),
		.imm_i(ex_imm),
		.result_o(alu_result)
	);

	branch_resolver u_branch (
		.br_cond_i(ex_br_cond),
		.jal_i(ex_jal),
		.jalr_i(ex_jalr),
		.pc_i(ex_pc),
		.imm_i(ex_imm),
		.rs1_data_i(ex_rs1_data),
		.rs2_data_i(ex_rs2_data),
		.pred_pc_i(ex_pred_pc),
		.next_pc_o(br_next_pc),
		.link_o(br_link),
		.mispredict_o(br_mispredict)
	);

	ex_merge u_merge (
		.clk(clk),
		.rst_i(rst_i),
		.valid_i(ex_valid),
		.out_ready_i(out_ready_i),
		.rd_we_i(ex_rd_we),
		.rd_addr_i(ex_rd_addr),
		.illegal_i(ex_illegal),
		.jal_i(ex_jal),
		.jalr_i(ex_jalr),
		.alu_result_i(alu_result),
		.link_i(br_link),
		.next_pc_i(br_next_pc),
		.mispredict_i(br_mispredict),
		.out_valid_o(out_valid_o),
		.rd_we_o(rd_we_o),
		.rd_addr_o(rd_addr_o),
		.rd_data_o(rd_data_o),
		.next_pc_o(next_pc_o),
		.redirect_o(redirect_o),
		.illegal_o(illegal_o),
		.flush_o(flush)
	);

endmodule

//--- ex_merge.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_merge (
	input logic clk,
	input logic rst_i,
	input logic valid_i,
	input logic out_ready_i,
	input logic rd_we_i,
	input logic [`EX_REGW-1:0] rd_addr_i,
	input logic illegal_i,
	input logic jal_i,
	input logic jalr_i,
	input logic [`EX_XLEN-1:0] alu_result_i,
	input logic [`EX_XLEN-1:0] link_i,
	input logic [`EX_XLEN-1:0] next_pc_i,
	input logic mispredict_i,
	output logic out_valid_o,
	output logic rd_we_o,
	output logic [`EX_REGW-1:0] rd_addr_o,
	output logic [`EX_XLEN-1:0] rd_data_o,
	output logic [`EX_XLEN-1:0] next_pc_o,
	output logic redirect_o,
	output logic illegal_o,
	output logic flush_o
);

	assign out_valid_o = valid_i;
	assign rd_we_o = valid_i && rd_we_i;
	assign rd_addr_o = rd_addr_i;
	assign rd_data_o = (jal_i || jalr_i) ? link_i : alu_result_i; // Jumps write the return address
	assign next_pc_o = next_pc_i;
	assign redirect_o = valid_i && mispredict_i;
	assign illegal_o = valid_i && illegal_i;

	// Wrong path is only known once the result leaves
	assign flush_o = redirect_o && out_ready_i;

	a_redirect_valid: assert property (@(posedge clk) disable iff (rst_i)
		redirect_o |-> out_valid_o);

	// Held result must not change until it is taken
	a_out_hold: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o
			&& $stable({rd_we_o, rd_addr_o, rd_data_o, next_pc_o, redirect_o, illegal_o}));

endmodule

//--- branch_resolver.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module branch_resolver
	import ex_pkg::*;
(
	input br_cond_e br_cond_i,
	input logic jal_i,
	input logic jalr_i,
	input logic [`EX_XLEN-1:0] pc_i,
	input logic [`EX_XLEN-1:0] imm_i,
	input logic [`EX_XLEN-1:0] rs1_data_i,
	input logic [`EX_XLEN-1:0] rs2_data_i,
	input logic [`EX_XLEN-1:0] pred_pc_i,
	output logic [`EX_XLEN-1:0] next_pc_o,
	output logic [`EX_XLEN-1:0] link_o,
	output logic mispredict_o
);

	logic eq, lt_s, lt_u;
	logic taken;
	logic [`EX_XLEN-1:0] pc_target, jalr_sum;

	assign eq = (rs1_data_i == rs2_data_i);
	assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign lt_u = (rs1_data_i < rs2_data_i);

	always_comb
	begin
		case (br_cond_i)
			BR_EQ: taken = eq;
			BR_NE: taken = !eq;
			BR_LT: taken = lt_s;
			BR_GE: taken = !lt_s;
			BR_LTU: taken = lt_u;
			BR_GEU: taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

	assign pc_target = pc_i + imm_i;
	assign jalr_sum = rs1_data_i + imm_i;
	assign link_o = pc_i + 'd4;

	always_comb
	begin
		if (jalr_i)
			next_pc_o = {jalr_sum[`EX_XLEN-1:1], 1'b0}; // Target LSB is dropped
		else if (jal_i || taken)
			next_pc_o = pc_target;
		else
			next_pc_o = link_o;
	end

	assign mispredict_o = (next_pc_o != pred_pc_i);

endmodule

//--- alu_unit.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module alu_unit
	import ex_pkg::*;
(
	input alu_op_e alu_op_i,
	input logic src_a_pc_i,
	input logic src_b_imm_i,
	input logic [`EX_XLEN-1:0] rs1_data_i,
	input logic [`EX_XLEN-1:0] rs2_data_i,
	input logic [`EX_XLEN-1:0] pc_i,
	input logic [`EX_XLEN-1:0] imm_i,
	output logic [`EX_XLEN-1:0] result_o
);

	logic [`EX_XLEN-1:0] op_a, op_b;
	logic [4:0] shamt;
	logic lt_s, lt_u;

	assign op_a = src_a_pc_i ? pc_i : rs1_data_i; // AUIPC uses the PC
	assign op_b = src_b_imm_i ? imm_i : rs2_data_i;
	assign shamt = op_b[4:0];

	assign lt_s = ($signed(op_a) < $signed(op_b));
	assign lt_u = (op_a < op_b);

	always_comb
	begin
		case (alu_op_i)
			ALU_ADD: result_o = op_a + op_b;
			ALU_SUB: result_o = op_a - op_b;
			ALU_SLL: result_o = op_a << shamt;
			ALU_SLT: result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
			ALU_XOR: result_o = op_a ^ op_b;
			ALU_SRL: result_o = op_a >> shamt;
			ALU_SRA: result_o = $unsigned($signed(op_a) >>> shamt);
			ALU_OR: result_o = op_a | op_b;
			ALU_AND: result_o = op_a & op_b;
			ALU_PASS_B: result_o = op_b; // LUI
			default: result_o = `EX_ZERO_WORD;
		endcase
	end

endmodule

//--- id_ex_regs.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module id_ex_regs
	import ex_pkg::*;
(
	input logic clk,
	input logic rst_i,
	input logic flush_i,
	input logic stall_i,
	input logic valid_i,
	input logic [`EX_XLEN-1:0] imm_i,
	input alu_op_e alu_op_i,
	input logic src_a_pc_i,
	input logic src_b_imm_i,
	input br_cond_e br_cond_i,
	input logic jal_i,
	input logic jalr_i,
	input logic rd_we_i,
	input logic [`EX_REGW-1:0] rd_addr_i,
	input logic [`EX_REGW-1:0] rs1_addr_i,
	input logic [`EX_REGW-1:0] rs2_addr_i,
	input logic illegal_i,
	input logic [`EX_XLEN-1:0] pc_i,
	input logic [`EX_XLEN-1:0] pred_pc_i,
	input logic [`EX_XLEN-1:0] rs1_data_i,
	input logic [`EX_XLEN-1:0] rs2_data_i,
	output logic valid_o,
	output logic [`EX_XLEN-1:0] imm_o,
	output alu_op_e alu_op_o,
	output logic src_a_pc_o,
	output logic src_b_imm_o,
	output br_cond_e br_cond_o,
	output logic jal_o,
	output logic jalr_o,
	output logic rd_we_o,
	output logic [`EX_REGW-1:0] rd_addr_o,
	output logic illegal_o,
	output logic [`EX_XLEN-1:0] pc_o,
	output logic [`EX_XLEN-1:0] pred_pc_o,
	output logic [`EX_XLEN-1:0] rs1_data_o,
	output logic [`EX_XLEN-1:0] rs2_data_o
);

	// Control fields, a flush turns the slot into a bubble
	always_ff @(posedge clk)
	begin
		if (rst_i || flush_i)
		begin
			valid_o <= 1'b0;
			rd_we_o <= 1'b0;
			br_cond_o <= BR_NONE;
			jal_o <= 1'b0;
			jalr_o <= 1'b0;
			illegal_o <= 1'b0;
		end
		else if (!stall_i)
		begin
			valid_o <= valid_i;
			rd_we_o <= rd_we_i;
			br_cond_o <= br_cond_i;
			jal_o <= jal_i;
			jalr_o <= jalr_i;
			illegal_o <= illegal_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_i)
		begin
			imm_o <= imm_i;
			alu_op_o <= alu_op_i;
			src_a_pc_o <= src_a_pc_i;
			src_b_imm_o <= src_b_imm_i;
			rd_addr_o <= rd_addr_i;
			pc_o <= pc_i;
			pred_pc_o <= pred_pc_i;
			// x0 always reads as zero
			rs1_data_o <= (rs1_addr_i == `EX_ZERO_REG) ? `EX_ZERO_WORD : rs1_data_i;
			rs2_data_o <= (rs2_addr_i == `EX_ZERO_REG) ? `EX_ZERO_WORD : rs2_data_i;
		end
	end

	a_stall_hold: assert property (@(posedge clk) disable iff (rst_i)
		stall_i && !flush_i |=> $stable({valid_o, imm_o, alu_op_o, src_a_pc_o, src_b_imm_o,
			br_cond_o, jal_o, jalr_o, rd_we_o, rd_addr_o, illegal_o, pc_o, pred_pc_o,
			rs1_data_o, rs2_data_o}));

	a_flush_bubble: assert property (@(posedge clk) disable iff (rst_i)
		flush_i |=> !valid_o);

endmodule

//--- insn_decoder.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module insn_decoder
	import ex_pkg::*;
(
	input insn_u insn_i,
	output logic [`EX_XLEN-1:0] imm_o,
	output alu_op_e alu_op_o,
	output logic src_a_pc_o,
	output logic src_b_imm_o,
	output br_cond_e br_cond_o,
	output logic jal_o,
	output logic jalr_o,
	output logic rd_we_o,
	output logic [`EX_REGW-1:0] rd_addr_o,
	output logic [`EX_REGW-1:0] rs1_addr_o,
	output logic [`EX_REGW-1:0] rs2_addr_o,
	output logic illegal_o
);

	logic [`EX_XLEN-1:0] imm_i_type, imm_b_type, imm_u_type, imm_j_type;
	logic alt; // Bit 30, picks SUB and SRA
	logic rd_nz;
	alu_op_e arith_op;
	br_cond_e cond;

	assign alt = insn_i.r.funct7[5];
	assign rd_nz = (insn_i.r.rd != `EX_ZERO_REG);
	assign rd_addr_o = insn_i.r.rd;

	assign imm_i_type = {{(`EX_XLEN-12){insn_i.r.funct7[6]}}, insn_i.r.funct7, insn_i.r.rs2};
	assign imm_u_type = {insn_i.r.funct7, insn_i.r.rs2, insn_i.r.rs1, insn_i.r.funct3, 12'b0};
	assign imm_b_type = {{(`EX_XLEN-13){insn_i.b.imm12}}, insn_i.b.imm12, insn_i.b.imm11,
		insn_i.b.imm10_5, insn_i.b.imm4_1, 1'b0};
	assign imm_j_type = {{(`EX_XLEN-20){insn_i.r.funct7[6]}}, insn_i.r.rs1, insn_i.r.funct3,
		insn_i.r.rs2[0], insn_i.r.funct7[5:0], insn_i.r.rs2[4:1], 1'b0};

	// Shared by OP and OP-IMM, SUB only exists in the register form
	always_comb
	begin
		case (insn_i.r.funct3)
			3'b000: arith_op = (alt && insn_i.r.opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb
	begin
		case (insn_i.b.funct3)
			3'b000: cond = BR_EQ;
			3'b001: cond = BR_NE;
			3'b100: cond = BR_LT;
			3'b101: cond = BR_GE;
			3'b110: cond = BR_LTU;
			3'b111: cond = BR_GEU;
			default: cond = BR_NONE; // Reserved encodings fall through
		endcase
	end

	always_comb
	begin
		imm_o = imm_i_type;
		alu_op_o = ALU_ADD;
		src_a_pc_o = 1'b0;
		src_b_imm_o = 1'b0;
		br_cond_o = BR_NONE;
		jal_o = 1'b0;
		jalr_o = 1'b0;
		rd_we_o = rd_nz;
		rs1_addr_o = insn_i.r.rs1;
		rs2_addr_o = `EX_ZERO_REG; // Only OP and BRANCH read rs2
		illegal_o = 1'b0;
		case (insn_i.r.opcode)
			OPC_OP:
			begin
				alu_op_o = arith_op;
				rs2_addr_o = insn_i.r.rs2;
			end
			OPC_OP_IMM:
			begin
				alu_op_o = arith_op;
				src_b_imm_o = 1'b1;
			end
			OPC_LUI:
			begin
				imm_o = imm_u_type;
				alu_op_o = ALU_PASS_B;
				src_b_imm_o = 1'b1;
				rs1_addr_o = `EX_ZERO_REG;
			end
			OPC_AUIPC:
			begin
				imm_o = imm_u_type;
				src_a_pc_o = 1'b1;
				src_b_imm_o = 1'b1;
				rs1_addr_o = `EX_ZERO_REG;
			end
			OPC_JAL:
			begin
				imm_o = imm_j_type;
				jal_o = 1'b1;
				rs1_addr_o = `EX_ZERO_REG;
			end
			OPC_JALR: jalr_o = 1'b1;
			OPC_BRANCH:
			begin
				imm_o = imm_b_type;
				br_cond_o = cond;
				rd_we_o = 1'b0;
				rs2_addr_o = insn_i.b.rs2;
			end
			default:
			begin
				rd_we_o = 1'b0;
				rs1_addr_o = `EX_ZERO_REG;
				illegal_o = 1'b1;
			end
		endcase
	end

endmodule

//--- ex_pkg.sv
package ex_pkg;

	// Major opcodes handled by this stage
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_cond_e;

	// Register and function fields
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} insn_r_t;

	// Branch layout with its scattered offset bits
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} insn_b_t;

	typedef union packed {
		insn_r_t r;
		insn_b_t b;
	} insn_u;

endpackage

//--- ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Datapath and address width, RV32I
`define EX_XLEN 32

// Register index width
`define EX_REGW 5

// Fill values for a bubble and for x0 reads
`define EX_ZERO_WORD {`EX_XLEN{1'b0}}
`define EX_ZERO_REG {`EX_REGW{1'b0}}

`endif
